//--- calc_bypass.sv
// Forwarding only sees fixed-latency results in the completion stages; long results must be in the register file
`timescale 1ns/100ps

module calc_bypass
 (input                                                    clk_i
  , input                                                  rst_i

  , input calc_pkg::dispatch_pkt_s                         dispatch_pkt_i
  , input calc_pkg::comp_stages_t                          comp_stages_i
  , input calc_pkg::word_t [calc_pkg::comp_stage_els_lp-1:0] comp_data_n_i

  , output calc_pkg::dispatch_pkt_s                        reservation_o
  );

  import calc_pkg::*;

  dispatch_pkt_s reservation_n, reservation_r;
  word_t         bypass_rs1, bypass_rs2;

  // Scan from the oldest stage down so the youngest match is the one that sticks
  function automatic word_t select_operand
    (input reg_addr_t                          addr
     , input word_t                            dispatch_data
     , input comp_stages_t                     stages
     , input word_t [comp_stage_els_lp-1:0]    fwd_data
     );
    word_t sel;
    sel = dispatch_data;
    for (int i = comp_stage_els_lp-1; i >= 0; i--)
      begin
        if (stages[i].w_v && (stages[i].rd_addr == addr) && (addr != '0))
          sel = fwd_data[i];
      end
    return sel;
  endfunction

  always_comb
    begin
      bypass_rs1 = select_operand(dispatch_pkt_i.rs1_addr
                                  ,dispatch_pkt_i.rs1
                                  ,comp_stages_i
                                  ,comp_data_n_i
                                  );
      bypass_rs2 = select_operand(dispatch_pkt_i.rs2_addr
                                  ,dispatch_pkt_i.rs2
                                  ,comp_stages_i
                                  ,comp_data_n_i
                                  );
    end

  // Patch the operands of the dispatched packet
  always_comb
    begin
      reservation_n     = dispatch_pkt_i;
      reservation_n.rs1 = bypass_rs1;
      reservation_n.rs2 = bypass_rs2;
    end

  always_ff @(posedge clk_i)
    begin
      reservation_r <= reservation_n;
      if (rst_i)
        reservation_r.v <= 1'b0;
    end

  assign reservation_o = reservation_r;

endmodule

//--- calc_completion.sv
// Fixed-latency results always win the writeback port; a long result waits for an empty slot
`timescale 1ns/100ps

module calc_completion
 (input                                                     clk_i
  , input                                                   rst_i

  , input calc_pkg::dispatch_pkt_s                          dispatch_pkt_i

  , input                                                   int_v_i
  , input calc_pkg::word_t                                  int_data_i
  , input                                                   mul_v_i
  , input calc_pkg::word_t                                  mul_data_i

  , input                                                   long_wb_v_i
  , input calc_pkg::wb_pkt_s                                long_wb_pkt_i
  , output logic                                            long_yumi_o

  , output calc_pkg::comp_stages_t                          comp_stages_o
  , output calc_pkg::word_t [calc_pkg::comp_stage_els_lp-1:0] comp_data_n_o

  , output calc_pkg::wb_pkt_s                               iwb_pkt_o
  , output logic                                            long_credit_o
  );

  import calc_pkg::*;

  wb_pkt_s [comp_stage_els_lp:0] stages_n;
  comp_stages_t                  stages_r;
  logic                          fixed_w_v;

  // Long ops never occupy a stage
  assign fixed_w_v = dispatch_pkt_i.v
                     & ~is_long_op(dispatch_pkt_i.op)
                     & (dispatch_pkt_i.rd_addr != '0);

  always_comb
    begin
      stages_n[0].w_v     = fixed_w_v;
      stages_n[0].rd_addr = dispatch_pkt_i.rd_addr;
      stages_n[0].rd_data = '0;
      for (int i = 1; i <= comp_stage_els_lp; i++)
        stages_n[i] = stages_r[i-1];

      // Single issue, so at most one pipe finishes into any stage
      stages_n[int_stage_lp].rd_data |= int_v_i ? int_data_i : '0;
      stages_n[mul_stage_lp].rd_data |= mul_v_i ? mul_data_i : '0;
    end

  always_ff @(posedge clk_i)
    begin
      stages_r <= stages_n[comp_stage_els_lp-1:0];
      if (rst_i)
        begin
          for (int i = 0; i < comp_stage_els_lp; i++)
            stages_r[i].w_v <= 1'b0;
        end
    end

  // Entry i carries what stage i+1 is about to hold
  always_comb
    begin
      for (int i = 0; i < comp_stage_els_lp; i++)
        comp_data_n_o[i] = stages_n[i+1].rd_data;
    end

  assign comp_stages_o = stages_r;

  assign long_yumi_o   = long_wb_v_i & ~stages_r[wb_stage_lp].w_v;
  assign iwb_pkt_o     = long_yumi_o ? long_wb_pkt_i : stages_r[wb_stage_lp];

  // One credit back per accepted long result
  assign long_credit_o = long_yumi_o;

endmodule

//--- calc_pipe_int.sv
// Purely combinational on the reservation; the result is only meaningful while int_v_o is high
`timescale 1ns/100ps

module calc_pipe_int
 (input calc_pkg::dispatch_pkt_s  reservation_i

  , output logic                  int_v_o
  , output calc_pkg::word_t       int_data_o
  );

  import calc_pkg::*;

  logic  int_op;
  word_t result;

  always_comb
    begin
      unique case (reservation_i.op)
        e_add, e_sub, e_and, e_or, e_xor, e_sll:
          int_op = 1'b1;
        default:
          int_op = 1'b0;
      endcase
    end

  always_comb
    begin
      unique case (reservation_i.op)
        e_add:
          result = reservation_i.rs1 + reservation_i.rs2;
        e_sub:
          result = reservation_i.rs1 - reservation_i.rs2;
        e_and:
          result = reservation_i.rs1 & reservation_i.rs2;
        e_or:
          result = reservation_i.rs1 | reservation_i.rs2;
        e_xor:
          result = reservation_i.rs1 ^ reservation_i.rs2;
        // Shift amount is the low five bits of rs2
        e_sll:
          result = reservation_i.rs1 << reservation_i.rs2[4:0];
        default:
          result = '0;
      endcase
    end

  assign int_v_o    = reservation_i.v & int_op;
  assign int_data_o = result;

endmodule

//--- calc_pipe_long.sv
// One divide at a time, accepted only in idle; the issuer must hold a credit before sending divu or remu
`timescale 1ns/100ps

module calc_pipe_long
 (input                            clk_i
  , input                          rst_i

  , input calc_pkg::dispatch_pkt_s reservation_i

  , output logic                   long_wb_v_o
  , output calc_pkg::wb_pkt_s      long_wb_pkt_o
  , input                          long_yumi_i
  );

  import calc_pkg::*;

  long_state_e                 state_r, state_n;
  logic                        accept;
  logic                        last_step;
  logic [div_cnt_width_lp-1:0] cnt_r;
  reg_addr_t                   rd_r;
  logic                        rem_sel_r;
  word_t                       quo_r, rem_r, divisor_r;
  logic [word_width_lp:0]      rem_shift, diff;

  assign accept    = (state_r == e_idle) & reservation_i.v & is_long_op(reservation_i.op);
  assign last_step = (cnt_r == div_cnt_width_lp'(div_cycles_lp-1));

  always_comb
    begin
      state_n = state_r;
      unique case (state_r)
        e_idle:
          if (accept)
            state_n = e_busy;
        e_busy:
          if (last_step)
            state_n = e_done;
        e_done:
          if (long_yumi_i)
            state_n = e_idle;
        default:
          state_n = e_idle;
      endcase
    end

  always_ff @(posedge clk_i)
    begin
      if (rst_i)
        state_r <= e_idle;
      else
        state_r <= state_n;
    end

  // Restoring step; a zero divisor naturally gives all ones and leaves the dividend as remainder
  assign rem_shift = {rem_r, quo_r[word_width_lp-1]};
  assign diff      = rem_shift - {1'b0, divisor_r};

  always_ff @(posedge clk_i)
    begin
      if (accept)
        begin
          rd_r      <= reservation_i.rd_addr;
          rem_sel_r <= (reservation_i.op == e_remu);
          quo_r     <= reservation_i.rs1;
          divisor_r <= reservation_i.rs2;
          rem_r     <= '0;
          cnt_r     <= '0;
        end
      else if (state_r == e_busy)
        begin
          quo_r <= {quo_r[word_width_lp-2:0], ~diff[word_width_lp]};
          rem_r <= diff[word_width_lp] ? rem_shift[word_width_lp-1:0] : diff[word_width_lp-1:0];
          cnt_r <= cnt_r + 1'b1;
        end
    end

  // rd of zero still completes so the credit comes back, but nothing is written
  assign long_wb_v_o           = (state_r == e_done);
  assign long_wb_pkt_o.w_v     = (rd_r != '0);
  assign long_wb_pkt_o.rd_addr = rd_r;
  assign long_wb_pkt_o.rd_data = rem_sel_r ? rem_r : quo_r;

endmodule

//--- calc_pipe_mul.sv
// Fully pipelined, one multiply may start every cycle; returns only the low word of the product
`timescale 1ns/100ps

module calc_pipe_mul
 (input                           clk_i
  , input                         rst_i

  , input calc_pkg::dispatch_pkt_s reservation_i

  , output logic                  mul_v_o
  , output calc_pkg::word_t       mul_data_o
  );

  import calc_pkg::*;

  logic  mul_issue;
  logic  opd_v_r, prod_v_r;
  word_t opd_a_r, opd_b_r;
  word_t prod_r;

  assign mul_issue = reservation_i.v & (reservation_i.op == e_mul);

  // Valid shift register, one bit per internal stage
  always_ff @(posedge clk_i)
    begin
      if (rst_i)
        begin
          opd_v_r  <= 1'b0;
          prod_v_r <= 1'b0;
        end
      else
        begin
          opd_v_r  <= mul_issue;
          prod_v_r <= opd_v_r;
        end
    end

  // Operand capture, then product
  always_ff @(posedge clk_i)
    begin
      opd_a_r <= reservation_i.rs1;
      opd_b_r <= reservation_i.rs2;
      prod_r  <= opd_a_r * opd_b_r;
    end

  // Lands in the completion pipe at mul_stage_lp on the next edge
  assign mul_v_o    = prod_v_r;
  assign mul_data_o = prod_r;

endmodule

//--- calc_pkg.sv
// Assumes a 32-bit datapath with 32 integer registers; x0 is never written and divide is unsigned only
package calc_pkg;

  localparam int word_width_lp     = 32;
  localparam int reg_addr_width_lp = 5;

  // Completion pipe geometry
  localparam int comp_stage_els_lp = 4;
  localparam int int_stage_lp      = 1;
  localparam int mul_stage_lp      = 3;
  localparam int wb_stage_lp       = 3;

  // Only one divide may be outstanding at a time
  localparam int long_credits_lp   = 1;
  localparam int div_cycles_lp     = 32;
  localparam int div_cnt_width_lp  = $clog2(div_cycles_lp);

  typedef logic [word_width_lp-1:0]     word_t;
  typedef logic [reg_addr_width_lp-1:0] reg_addr_t;

  typedef enum logic [3:0]
  {
    e_add  = 4'd0
    ,e_sub  = 4'd1
    ,e_and  = 4'd2
    ,e_or   = 4'd3
    ,e_xor  = 4'd4
    ,e_sll  = 4'd5
    ,e_mul  = 4'd6
    ,e_divu = 4'd7
    ,e_remu = 4'd8
  } calc_op_e;

  typedef struct packed
  {
    logic      v;
    calc_op_e  op;
    reg_addr_t rd_addr;
    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    word_t     rs1;
    word_t     rs2;
  } dispatch_pkt_s;

  typedef struct packed
  {
    logic      w_v;
    reg_addr_t rd_addr;
    word_t     rd_data;
  } wb_pkt_s;

  // Index 0 is the youngest stage
  typedef wb_pkt_s [comp_stage_els_lp-1:0] comp_stages_t;

  typedef enum logic [1:0]
  {
    e_idle = 2'd0
    ,e_busy = 2'd1
    ,e_done = 2'd2
  } long_state_e;

  // Ops that go to the variable latency pipe instead of the completion stages
  function automatic logic is_long_op(calc_op_e op);
    return (op == e_divu) || (op == e_remu);
  endfunction

endpackage

//--- calc_top.sv
// Writeback has no back-pressure; the issuer tracks long credits and the forwarding distance rules
`timescale 1ns/100ps

module calc_top
 (input                             clk_i
  , input                           rst_i

  , input calc_pkg::dispatch_pkt_s  dispatch_pkt_i

  , output calc_pkg::wb_pkt_s       iwb_pkt_o
  , output logic                    long_credit_o
  );

  import calc_pkg::*;

  dispatch_pkt_s                   reservation;
  comp_stages_t                    comp_stages_r;
  word_t [comp_stage_els_lp-1:0]   comp_data_n;

  logic    int_v, mul_v;
  word_t   int_data, mul_data;
  logic    long_wb_v, long_yumi;
  wb_pkt_s long_wb_pkt;

  calc_bypass
   bypass
    (.clk_i(clk_i)
     ,.rst_i(rst_i)
     ,.dispatch_pkt_i(dispatch_pkt_i)
     ,.comp_stages_i(comp_stages_r)
     ,.comp_data_n_i(comp_data_n)
     ,.reservation_o(reservation)
     );

  // 1 cycle
  calc_pipe_int
   pipe_int
    (.reservation_i(reservation)
     ,.int_v_o(int_v)
     ,.int_data_o(int_data)
     );

  // 3 cycles
  calc_pipe_mul
   pipe_mul
    (.clk_i(clk_i)
     ,.rst_i(rst_i)
     ,.reservation_i(reservation)
     ,.mul_v_o(mul_v)
     ,.mul_data_o(mul_data)
     );

  // Variable latency, arbitrated into free writeback slots
  calc_pipe_long
   pipe_long
    (.clk_i(clk_i)
     ,.rst_i(rst_i)
     ,.reservation_i(reservation)
     ,.long_wb_v_o(long_wb_v)
     ,.long_wb_pkt_o(long_wb_pkt)
     ,.long_yumi_i(long_yumi)
     );

  calc_completion
   completion
    (.clk_i(clk_i)
     ,.rst_i(rst_i)
     ,.dispatch_pkt_i(dispatch_pkt_i)
     ,.int_v_i(int_v)
     ,.int_data_i(int_data)
     ,.mul_v_i(mul_v)
     ,.mul_data_i(mul_data)
     ,.long_wb_v_i(long_wb_v)
     ,.long_wb_pkt_i(long_wb_pkt)
     ,.long_yumi_o(long_yumi)
     ,.comp_stages_o(comp_stages_r)
     ,.comp_data_n_o(comp_data_n)
     ,.iwb_pkt_o(iwb_pkt_o)
     ,.long_credit_o(long_credit_o)
     );

endmodule

//--- list.f
calc_pkg.sv
calc_bypass.sv
calc_pipe_int.sv
calc_pipe_mul.sv
calc_pipe_long.sv
calc_completion.sv
calc_top.sv
tb_calc_checker.sv
tb_calc.sv

//--- run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --timescale 1ns/100ps --top-module tb_calc \
  -f list.f -o tb_calc_sim &&
  ./obj_dir/tb_calc_sim > sim.log 2>&1 ;
cat sim.log 2>/dev/null
grep -qx "Test passed" sim.log && echo "simulation passed" && exit 0 ||
  { echo "simulation failed"; exit 1; }

//--- tb_calc.sv
// Applies the stimulus table twice, the second pass with random bubbles; one divide in flight at most
`timescale 1ns/100ps

module tb_calc;

  import calc_pkg::*;

  localparam int wait_limit_lp = 200;
  localparam int rows_lp       = 26;

  typedef struct packed
  {
    calc_op_e   op;
    reg_addr_t  rd;
    reg_addr_t  rs1;
    reg_addr_t  rs2;
    logic [7:0] count;
  } stim_row_s;

  logic          clk, rst;
  dispatch_pkt_s dispatch_pkt;
  wb_pkt_s       iwb_pkt;
  logic          long_credit;

  // Issuer view of the register file, filled from writeback only
  word_t         regs [32];
  int unsigned   ready_edge [32];
  logic          long_busy [32];
  int            credits;
  int unsigned   cyc;
  logic [31:0]   rng;
  logic          aborted;
  int            tb_errors;
  int            mismatch_cnt, other_cnt, longs_issued, credits_returned;

  // op, rd, rs1, rs2, times issued
  stim_row_s stim_table [rows_lp] = '{
    '{e_add,  5'd1,  5'd2,  5'd3,  8'd1},
    '{e_sub,  5'd4,  5'd1,  5'd5,  8'd1},
    '{e_and,  5'd6,  5'd4,  5'd7,  8'd1},
    '{e_or,   5'd8,  5'd6,  5'd1,  8'd1},
    '{e_xor,  5'd9,  5'd8,  5'd4,  8'd1},
    '{e_sll,  5'd10, 5'd9,  5'd2,  8'd1},
    '{e_mul,  5'd11, 5'd10, 5'd3,  8'd1},
    '{e_mul,  5'd12, 5'd11, 5'd11, 8'd1},
    '{e_add,  5'd13, 5'd12, 5'd11, 8'd1},
    '{e_add,  5'd0,  5'd1,  5'd2,  8'd2},
    '{e_divu, 5'd14, 5'd13, 5'd6,  8'd1},
    '{e_remu, 5'd15, 5'd13, 5'd6,  8'd1},
    '{e_divu, 5'd16, 5'd15, 5'd0,  8'd1},
    '{e_remu, 5'd17, 5'd9,  5'd0,  8'd1},
    '{e_divu, 5'd18, 5'd17, 5'd14, 8'd1},
    '{e_divu, 5'd19, 5'd5,  5'd7,  8'd1},
    '{e_add,  5'd20, 5'd20, 5'd21, 8'd40},
    '{e_mul,  5'd22, 5'd20, 5'd19, 8'd1},
    '{e_remu, 5'd0,  5'd3,  5'd4,  8'd1},
    '{e_mul,  5'd23, 5'd23, 5'd2,  8'd3},
    '{e_mul,  5'd24, 5'd5,  5'd7,  8'd1},
    '{e_mul,  5'd25, 5'd8,  5'd9,  8'd1},
    '{e_mul,  5'd26, 5'd24, 5'd25, 8'd1},
    '{e_sub,  5'd27, 5'd26, 5'd12, 8'd1},
    '{e_sll,  5'd28, 5'd27, 5'd26, 8'd1},
    '{e_xor,  5'd0,  5'd28, 5'd27, 8'd1}
  };

  calc_top dut0
    (.clk_i(clk)
     ,.rst_i(rst)
     ,.dispatch_pkt_i(dispatch_pkt)
     ,.iwb_pkt_o(iwb_pkt)
     ,.long_credit_o(long_credit)
     );

  tb_calc_checker checker0
    (.clk_i(clk)
     ,.rst_i(rst)
     ,.dispatch_pkt_i(dispatch_pkt)
     ,.iwb_pkt_i(iwb_pkt)
     ,.long_credit_i(long_credit)
     ,.mismatch_cnt_o(mismatch_cnt)
     ,.other_cnt_o(other_cnt)
     ,.longs_issued_o(longs_issued)
     ,.credits_returned_o(credits_returned)
     );

  initial
    begin
      clk = 1'b0;
      forever #5 clk = ~clk;
    end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic is_divide(input calc_op_e op);
    return (op == e_divu) || (op == e_remu);
  endfunction

  // Register sources need a visible producer, a pending divide blocks readers and writers
  function automatic logic can_issue(input stim_row_s row);
    logic ok;
    ok = !long_busy[row.rd] && !long_busy[row.rs1] && !long_busy[row.rs2];
    if (row.rs1 != '0)
      ok &= (cyc + 1 >= ready_edge[row.rs1]);
    if (row.rs2 != '0)
      ok &= (cyc + 1 >= ready_edge[row.rs2]);
    if (is_divide(row.op))
      ok &= (credits > 0);
    return ok;
  endfunction

  // Outputs are read mid-cycle where they are stable, then the rising edge is awaited
  task automatic next_edge();
    @(negedge clk);
    if (!rst && iwb_pkt.w_v && (iwb_pkt.rd_addr != '0))
      regs[iwb_pkt.rd_addr] = iwb_pkt.rd_data;
    if (!rst && long_credit)
      begin
        credits++;
        if (iwb_pkt.w_v)
          long_busy[iwb_pkt.rd_addr] = 1'b0;
      end
    @(posedge clk);
    cyc++;
  endtask

  task automatic drive(input dispatch_pkt_s pkt);
    #1;
    dispatch_pkt = pkt;
  endtask

  task automatic wait_idle_cycle(input string what, inout int waited);
    drive('0);
    next_edge();
    waited++;
    if (waited > wait_limit_lp && !aborted)
      begin
        $display("timeout at %0t: gave up waiting for %s", $time, what);
        tb_errors++;
        aborted = 1'b1;
      end
  endtask

  task automatic issue_row(input stim_row_s row, input logic bubbles);
    dispatch_pkt_s pkt;
    int            waited;
    waited = 0;
    rng = xorshift32(rng);
    if (bubbles && (rng[1:0] == 2'b00))
      begin
        drive('0);
        next_edge();
      end
    while (!can_issue(row) && !aborted)
      wait_idle_cycle("operands or a long credit", waited);
    if (!aborted)
      begin
        pkt          = '0;
        pkt.v        = 1'b1;
        pkt.op       = row.op;
        pkt.rd_addr  = row.rd;
        pkt.rs1_addr = row.rs1;
        pkt.rs2_addr = row.rs2;
        pkt.rs1      = regs[row.rs1];
        pkt.rs2      = regs[row.rs2];
        if (is_divide(row.op))
          begin
            credits--;
            long_busy[row.rd] = (row.rd != '0);
          end
        else
          ready_edge[row.rd] = cyc + ((row.op == e_mul) ? 4 : 2);
        drive(pkt);
        next_edge();
      end
  endtask

  task automatic report();
    if (longs_issued != credits_returned)
      begin
        $display("divides issued %0d but credits returned %0d", longs_issued, credits_returned);
        tb_errors++;
      end
    $display("errors: %0d mismatch, %0d other, %0d testbench", mismatch_cnt, other_cnt, tb_errors);
    if (mismatch_cnt + other_cnt + tb_errors == 0)
      $display("Test passed");
    else
      $display("Test failed");
    $finish;
  endtask

  initial
    begin
      int waited;
      rst          = 1'b1;
      dispatch_pkt = '0;
      cyc          = 0;
      credits      = long_credits_lp;
      aborted      = 1'b0;
      tb_errors    = 0;
      waited       = 0;
      rng          = 32'd84;
      for (int i = 0; i < 32; i++)
        begin
          rng           = xorshift32(rng);
          regs[i]       = (i == 0) ? '0 : rng;
          ready_edge[i] = 0;
          long_busy[i]  = 1'b0;
        end
      repeat (10) next_edge();
      #1;
      rst = 1'b0;
      next_edge();
      // Quiet period, no writeback or credit may show up
      repeat (6)
        begin
          drive('0);
          next_edge();
        end
      for (int pass = 0; pass < 2; pass++)
        begin
          for (int r = 0; r < rows_lp; r++)
            for (int n = 0; n < stim_table[r].count; n++)
              if (!aborted)
                issue_row(stim_table[r], pass == 1);
        end
      while (credits != long_credits_lp && !aborted)
        wait_idle_cycle("the last divide to write back", waited);
      repeat (comp_stage_els_lp + 2)
        begin
          drive('0);
          next_edge();
        end
      report();
    end

endmodule

//--- tb_calc_checker.sv
// Assumes in-order single issue; a register never written takes its value from the first dispatch that reads it
`timescale 1ns/100ps

module tb_calc_checker
 (input                              clk_i
  , input                            rst_i
  , input calc_pkg::dispatch_pkt_s   dispatch_pkt_i
  , input calc_pkg::wb_pkt_s         iwb_pkt_i
  , input                            long_credit_i
  , output int                       mismatch_cnt_o
  , output int                       other_cnt_o
  , output int                       longs_issued_o
  , output int                       credits_returned_o
  );

  import calc_pkg::*;

  typedef struct packed
  {
    int unsigned due;
    reg_addr_t   rd;
    word_t       data;
  } expect_s;

  expect_s     fixed_q [$];
  expect_s     long_q [$];
  word_t       model [32];
  logic [31:0] known = '0;
  int unsigned cyc = 0;
  int          mismatch_cnt = 0;
  int          other_cnt = 0;
  int          longs_issued = 0;
  int          credits_returned = 0;

  assign mismatch_cnt_o     = mismatch_cnt;
  assign other_cnt_o        = other_cnt;
  assign longs_issued_o     = longs_issued;
  assign credits_returned_o = credits_returned;

  function automatic word_t expected_result(input calc_op_e op, input word_t a, input word_t b);
    case (op)
      e_add:   return a + b;
      e_sub:   return a - b;
      e_and:   return a & b;
      e_or:    return a | b;
      e_xor:   return a ^ b;
      e_sll:   return a << b[4:0];
      e_mul:   return a * b;
      e_divu:  return (b == '0) ? '1 : a / b;
      e_remu:  return (b == '0) ? a : a % b;
      default: return '0;
    endcase
  endfunction

  function automatic word_t operand(input reg_addr_t addr, input word_t dispatched);
    if (addr == '0)
      return '0;
    return known[addr] ? model[addr] : dispatched;
  endfunction

  task automatic report_error(input string msg);
    other_cnt++;
    $display("error at %0t: %s", $time, msg);
  endtask

  task automatic report_mismatch(input string what, input expect_s exp);
    mismatch_cnt++;
    $display("mismatch at %0t: %s writeback w_v %0b rd %0d data %h, expected rd %0d data %h",
             $time, what, iwb_pkt_i.w_v, iwb_pkt_i.rd_addr, iwb_pkt_i.rd_data, exp.rd, exp.data);
  endtask

  task automatic check_writeback();
    expect_s exp;
    logic    bad;
    if (long_credit_i)
      begin
        credits_returned++;
        if (long_q.size() == 0)
          report_error("long credit returned with no divide outstanding");
        else
          begin
            exp = long_q.pop_front();
            if (cyc < exp.due)
              report_error($sformatf("divide for rd %0d finished too early", exp.rd));
            // A divide into x0 returns its credit without writing
            if (exp.rd == '0)
              bad = (iwb_pkt_i.w_v !== 1'b0);
            else
              bad = (iwb_pkt_i.w_v !== 1'b1) || (iwb_pkt_i.rd_addr !== exp.rd)
                    || (iwb_pkt_i.rd_data !== exp.data);
            if (bad)
              report_mismatch("divide", exp);
          end
      end
    else if (iwb_pkt_i.w_v)
      begin
        if (fixed_q.size() == 0 || fixed_q[0].due != cyc)
          report_error($sformatf("unexpected writeback to rd %0d", iwb_pkt_i.rd_addr));
        else
          begin
            exp = fixed_q.pop_front();
            if ((iwb_pkt_i.rd_addr !== exp.rd) || (iwb_pkt_i.rd_data !== exp.data))
              report_mismatch("fixed", exp);
          end
      end
    while (fixed_q.size() != 0 && fixed_q[0].due <= cyc)
      begin
        exp = fixed_q.pop_front();
        report_error($sformatf("missing writeback for rd %0d", exp.rd));
      end
  endtask

  task automatic record_dispatch();
    word_t   a, b;
    expect_s exp;
    a        = operand(dispatch_pkt_i.rs1_addr, dispatch_pkt_i.rs1);
    b        = operand(dispatch_pkt_i.rs2_addr, dispatch_pkt_i.rs2);
    exp.rd   = dispatch_pkt_i.rd_addr;
    exp.data = expected_result(dispatch_pkt_i.op, a, b);
    if ((dispatch_pkt_i.op == e_divu) || (dispatch_pkt_i.op == e_remu))
      begin
        longs_issued++;
        exp.due = cyc + div_cycles_lp + 2;
        long_q.push_back(exp);
      end
    else if (exp.rd != '0)
      begin
        exp.due = cyc + comp_stage_els_lp;
        fixed_q.push_back(exp);
      end
    if (exp.rd != '0)
      begin
        model[exp.rd] = exp.data;
        known[exp.rd] = 1'b1;
      end
  endtask

  // Mid-cycle sampling sees the values the next rising edge will capture
  always @(negedge clk_i)
    begin
      cyc++;
      if (!rst_i)
        begin
          check_writeback();
          if (dispatch_pkt_i.v)
            record_dispatch();
        end
    end

endmodule
